// File: design/sdramPkg.sv
// SDRAM controller package
// geometry and bus widths as plain vector typedefs
// chip command encodings and the mode register word
// timing constants in Clk cycles
// state enums for the core FSM and the sequencing submodules
package sdramPkg;

    typedef logic [1:0]  bankT;
    typedef logic [10:0] rowT;
    typedef logic [7:0]  colT;
    typedef logic [20:0] hostAddrT;                   // bank, row, column
    typedef logic [10:0] chipAddrT;
    typedef logic [31:0] dataT;
    typedef logic [3:0]  maskT;                       // 1 blocks the byte
    typedef logic [3:0]  cmdT;                        // CS_n RAS_n CAS_n WE_n

    localparam cmdT CmdNop       = 4'b0111;
    localparam cmdT CmdActive    = 4'b0011;
    localparam cmdT CmdRead      = 4'b0101;
    localparam cmdT CmdWrite     = 4'b0100;
    localparam cmdT CmdPrecharge = 4'b0010;
    localparam cmdT CmdRefresh   = 4'b0001;
    localparam cmdT CmdLoadMode  = 4'b0000;

    // burst length 1, sequential, CAS latency 2
    localparam chipAddrT ModeRegValue = 11'b000_0010_0000;
    localparam int PrechargeAllBit = 10;

    localparam int InitWaitCycles  = 100;             // shortened power-up wait
    localparam int TrpCycles       = 2;
    localparam int TrcdCycles      = 2;
    localparam int TrfcCycles      = 7;
    localparam int TmrdCycles      = 2;
    localparam int TwrCycles       = 2;
    localparam int CasLatency      = 2;
    localparam int RefreshInterval = 390;

    localparam int TimerW = 9;

    typedef enum logic [2:0] {
        CoreInit, CoreIdle, CoreRefresh, CoreAccess, CoreAckWait
    } coreStateT;

    typedef enum logic [2:0] {
        SeqStart, SeqWaitPre, SeqWaitAct, SeqWaitData, SeqFinish,
        SeqWait, SeqRefresh, SeqMode
    } seqStateT;

endpackage

// File: design/sdramInit.sv
// SDRAM power-up sequence
// wait, precharge-all, two auto-refreshes, mode register load
// InitDone stays high until the next reset
module sdramInit
    import sdramPkg::*;
(
    input  logic     Clk,
    input  logic     reset,
    output cmdT      Cmd,
    output chipAddrT ChipAddr,
    output logic     InitDone
);

    seqStateT          state;
    logic [TimerW-1:0] timer;
    logic              secondRefresh;               // first refresh already issued

    always_ff @(posedge Clk) begin
        if (reset) begin
            state         <= SeqWait;
            timer         <= TimerW'(InitWaitCycles - 1);
            secondRefresh <= 1'b0;
            Cmd           <= CmdNop;
            ChipAddr      <= '0;
            InitDone      <= 1'b0;
        end else begin
            Cmd      <= CmdNop;
            ChipAddr <= '0;
            if (timer != '0) begin
                timer <= timer - 1'b1;
            end
            case (state)
                SeqWait: if (timer == '0) begin
                    Cmd                       <= CmdPrecharge;
                    ChipAddr[PrechargeAllBit] <= 1'b1;  // all banks
                    timer                     <= TimerW'(TrpCycles - 1);
                    state                     <= SeqWaitPre;
                end
                SeqWaitPre: if (timer == '0) begin
                    Cmd   <= CmdRefresh;
                    timer <= TimerW'(TrfcCycles - 1);
                    state <= SeqRefresh;
                end
                SeqRefresh: if (timer == '0) begin
                    if (!secondRefresh) begin
                        Cmd           <= CmdRefresh;
                        timer         <= TimerW'(TrfcCycles - 1);
                        secondRefresh <= 1'b1;
                    end else begin
                        Cmd      <= CmdLoadMode;
                        ChipAddr <= ModeRegValue;
                        timer    <= TimerW'(TmrdCycles - 1);
                        state    <= SeqMode;
                    end
                end
                SeqMode: if (timer == '0) begin
                    InitDone <= 1'b1;
                    state    <= SeqFinish;
                end
                SeqFinish: state <= SeqFinish;      // parked until reset
                default: state <= SeqWait;
            endcase
        end
    end

endmodule

// File: design/refreshEngine.sv
// Auto-refresh engine
// interval counter that raises RefreshPending
// precharge-all then refresh sequence once the core grants it
module refreshEngine
    import sdramPkg::*;
(
    input  logic     Clk,
    input  logic     reset,
    input  logic     InitDone,
    input  logic     RefreshGrant,
    output logic     RefreshPending,
    output logic     RefreshDone,
    output cmdT      Cmd,
    output chipAddrT ChipAddr
);

    seqStateT          state;
    logic [TimerW-1:0] timer;
    logic [TimerW-1:0] intervalCnt;
    logic              seqEnd;

    assign seqEnd = (state == SeqRefresh) && (timer == '0);

    // interval counter, the overrun while waiting for a grant carries over
    always_ff @(posedge Clk) begin
        if (reset) begin
            intervalCnt    <= '0;
            RefreshPending <= 1'b0;
        end else if (seqEnd) begin
            intervalCnt    <= intervalCnt - TimerW'(RefreshInterval);
            RefreshPending <= 1'b0;
        end else if (InitDone) begin
            if (intervalCnt != '1) begin
                intervalCnt <= intervalCnt + 1'b1;  // saturate
            end
            if (intervalCnt == TimerW'(RefreshInterval - 1)) begin
                RefreshPending <= 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state       <= SeqStart;
            timer       <= '0;
            Cmd         <= CmdNop;
            ChipAddr    <= '0;
            RefreshDone <= 1'b0;
        end else begin
            Cmd         <= CmdNop;
            ChipAddr    <= '0;
            RefreshDone <= seqEnd;
            if (timer != '0) begin
                timer <= timer - 1'b1;
            end
            case (state)
                SeqStart: if (RefreshGrant) begin
                    Cmd                       <= CmdPrecharge;
                    ChipAddr[PrechargeAllBit] <= 1'b1;
                    timer                     <= TimerW'(TrpCycles - 1);
                    state                     <= SeqWaitPre;
                end
                SeqWaitPre: if (timer == '0) begin
                    Cmd   <= CmdRefresh;
                    timer <= TimerW'(TrfcCycles - 1);
                    state <= SeqRefresh;
                end
                SeqRefresh: if (timer == '0) state <= SeqFinish;
                SeqFinish: state <= SeqStart;       // grant drops meanwhile
                default: state <= SeqStart;
            endcase
        end
    end

endmodule

// File: design/accessSequencer.sv
// Single host access sequencer
// precharge-all, activate, then read or write of one word
// read data capture CasLatency+1 cycles after the read command
// write data and byte mask driven with the write command only
module accessSequencer
    import sdramPkg::*;
(
    input  logic     Clk,
    input  logic     reset,
    input  logic     Start,
    input  logic     Write,
    input  hostAddrT Addr,
    input  dataT     WrData,
    input  maskT     WrMask,
    input  dataT     ChipDin,
    output cmdT      Cmd,
    output chipAddrT ChipAddr,
    output bankT     ChipBank,
    output dataT     ChipDout,
    output maskT     ChipDqm,
    output dataT     RdData,
    output logic     Done
);

    seqStateT          state;
    logic [TimerW-1:0] timer;
    bankT              bank;
    rowT               row;
    colT               col;
    logic              issueWrite;
    logic              captureRead;

    assign {bank, row, col} = Addr;

    assign issueWrite  = (state == SeqWaitAct) && (timer == '0) && Write;
    assign captureRead = (state == SeqWaitData) && (timer == '0) && !Write;

    always_ff @(posedge Clk) begin
        if (reset) begin
            state    <= SeqStart;
            timer    <= '0;
            Cmd      <= CmdNop;
            ChipAddr <= '0;
            ChipBank <= '0;
            ChipDqm  <= '0;
            Done     <= 1'b0;
        end else begin
            Cmd      <= CmdNop;
            ChipAddr <= '0;
            ChipBank <= '0;
            ChipDqm  <= '0;
            Done     <= 1'b0;
            if (timer != '0) begin
                timer <= timer - 1'b1;
            end
            case (state)
                SeqStart: if (Start) begin
                    Cmd                       <= CmdPrecharge;
                    ChipAddr[PrechargeAllBit] <= 1'b1;
                    timer                     <= TimerW'(TrpCycles - 1);
                    state                     <= SeqWaitPre;
                end
                SeqWaitPre: if (timer == '0) begin
                    Cmd      <= CmdActive;
                    ChipAddr <= row;
                    ChipBank <= bank;
                    timer    <= TimerW'(TrcdCycles - 1);
                    state    <= SeqWaitAct;
                end
                SeqWaitAct: if (timer == '0) begin
                    ChipAddr <= chipAddrT'(col);    // A10 low, no auto-precharge
                    ChipBank <= bank;
                    state    <= SeqWaitData;
                    if (Write) begin
                        Cmd     <= CmdWrite;
                        ChipDqm <= WrMask;
                        timer   <= TimerW'(TwrCycles - 1);  // write recovery
                    end else begin
                        Cmd   <= CmdRead;
                        timer <= TimerW'(CasLatency);       // capture edge
                    end
                end
                SeqWaitData: if (timer == '0) begin
                    Done  <= 1'b1;
                    state <= SeqFinish;
                end
                SeqFinish: if (!Start) state <= SeqStart;   // core left Access
                default: state <= SeqStart;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        ChipDout <= issueWrite ? WrData : '0;
        if (captureRead) begin
            RdData <= ChipDin;
        end
    end

endmodule

// File: design/sdramCore.sv
// SDRAM controller top level
// core FSM arbitrating refresh against host accesses
// four-phase Req/Ack host handshake with request latch
// chip pin multiplexing, inverted chip clock, CKE tied high
module sdramCore
    import sdramPkg::*;
(
    input  logic     Clk,
    input  logic     reset,
    input  logic     Req,
    input  logic     Write,
    input  hostAddrT Addr,
    input  dataT     WrData,
    input  maskT     WrMask,
    output logic     Ack,
    output dataT     RdData,
    output logic     InitDone,
    input  dataT     ChipDin,
    output dataT     ChipDout,
    output chipAddrT ChipAddr,
    output bankT     ChipBank,
    output logic     ChipClk,
    output logic     ChipCke,
    output logic     ChipCsN,
    output logic     ChipRasN,
    output logic     ChipCasN,
    output logic     ChipWeN,
    output maskT     ChipDqm
);

    coreStateT state;

    // latched host request
    logic     reqWrite;
    hostAddrT reqAddr;
    dataT     reqData;
    maskT     reqMask;

    cmdT      initCmd;
    chipAddrT initAddr;
    cmdT      refCmd;
    chipAddrT refAddr;
    logic     refreshPending;
    logic     refreshDone;
    logic     refreshGrant;
    cmdT      seqCmd;
    chipAddrT seqAddr;
    bankT     seqBank;
    dataT     seqDout;
    maskT     seqDqm;
    logic     seqStart;
    logic     seqDone;
    cmdT      pinCmd;

    assign refreshGrant = (state == CoreRefresh);
    assign seqStart     = (state == CoreAccess);
    assign Ack          = (state == CoreAckWait);

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= CoreInit;
        end else begin
            case (state)
                CoreInit: if (InitDone) state <= CoreIdle;
                CoreIdle: begin
                    if (refreshPending) begin
                        state <= CoreRefresh;       // refresh wins
                    end else if (Req) begin
                        state <= CoreAccess;
                    end
                end
                CoreRefresh: if (refreshDone) state <= CoreIdle;
                CoreAccess: if (seqDone) state <= CoreAckWait;
                CoreAckWait: if (!Req) state <= CoreIdle;  // hold Ack while Req high
                default: state <= CoreInit;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (state == CoreIdle && !refreshPending && Req) begin
            reqWrite <= Write;
            reqAddr  <= Addr;
            reqData  <= WrData;
            reqMask  <= WrMask;
        end
    end

    always_comb begin
        pinCmd   = CmdNop;
        ChipAddr = '0;
        ChipBank = '0;
        ChipDout = '0;
        ChipDqm  = '0;
        case (state)
            CoreInit: begin
                pinCmd   = initCmd;
                ChipAddr = initAddr;
            end
            CoreRefresh: begin
                pinCmd   = refCmd;
                ChipAddr = refAddr;
            end
            CoreAccess: begin
                pinCmd   = seqCmd;
                ChipAddr = seqAddr;
                ChipBank = seqBank;
                ChipDout = seqDout;
                ChipDqm  = seqDqm;
            end
            default: pinCmd = CmdNop;               // idle and Ack wait
        endcase
    end

    assign {ChipCsN, ChipRasN, ChipCasN, ChipWeN} = pinCmd;
    assign ChipClk = ~Clk;                          // chip samples mid-cycle
    assign ChipCke = 1'b1;

    sdramInit sdramInit_i (
        .Clk      (Clk),
        .reset    (reset),
        .Cmd      (initCmd),
        .ChipAddr (initAddr),
        .InitDone (InitDone)
    );

    refreshEngine refreshEngine_i (
        .Clk            (Clk),
        .reset          (reset),
        .InitDone       (InitDone),
        .RefreshGrant   (refreshGrant),
        .RefreshPending (refreshPending),
        .RefreshDone    (refreshDone),
        .Cmd            (refCmd),
        .ChipAddr       (refAddr)
    );

    accessSequencer accessSequencer_i (
        .Clk      (Clk),
        .reset    (reset),
        .Start    (seqStart),
        .Write    (reqWrite),
        .Addr     (reqAddr),
        .WrData   (reqData),
        .WrMask   (reqMask),
        .ChipDin  (ChipDin),
        .Cmd      (seqCmd),
        .ChipAddr (seqAddr),
        .ChipBank (seqBank),
        .ChipDout (seqDout),
        .ChipDqm  (seqDqm),
        .RdData   (RdData),
        .Done     (seqDone)
    );

endmodule

// File: verif/sdramModel.sv
// Behavioral SDR SDRAM for the controller testbench
// command decode on the rising chip clock, open row per bank
// byte-masked word store, read data CasLatency edges after the read
// checks for missing precharge and for refresh spacing after init
module sdramModel
    import sdramPkg::*;
(
    input  logic     Clk,
    input  logic     Cke,
    input  logic     CsN,
    input  logic     RasN,
    input  logic     CasN,
    input  logic     WeN,
    input  chipAddrT Addr,
    input  bankT     Bank,
    input  maskT     Dqm,
    input  dataT     DqIn,
    output dataT     DqOut,
    output int       ErrorCount
);

    localparam int RefreshLimit = RefreshInterval + 60;
    // reserved, burst write, op mode, CAS latency, sequential, burst length 1
    localparam chipAddrT ModeWord = {1'b0, 1'b0, 2'b00, 3'(CasLatency), 1'b0, 3'b000};

    dataT mem [hostAddrT];                          // written words only
    bit   bankOpen [4];
    rowT  openRow [4];
    bit   pipeValid [CasLatency];
    dataT pipeData [CasLatency];
    bit   modeLoaded;
    bit   spacingReported;
    int   sinceRefresh;
    dataT fillKey;
    bit   keyDrawn;

    // unwritten words read as a pattern over every address bit
    function automatic dataT storedWord(hostAddrT a);
        return mem.exists(a) ? mem[a] : (fillKey ^ {a[10:0], a});
    endfunction

    always @(posedge Clk) begin
        cmdT      cmd;
        hostAddrT wordAddr;
        dataT     word;
        cmd      = {CsN, RasN, CasN, WeN};
        wordAddr = {Bank, openRow[Bank], Addr[7:0]};
        DqOut <= pipeValid[0] ? pipeData[0] : '0;   // read data pipeline
        for (int i = 0; i < CasLatency - 1; i++) begin
            pipeValid[i] = pipeValid[i + 1];
            pipeData[i]  = pipeData[i + 1];
        end
        pipeValid[CasLatency - 1] = 1'b0;
        if (modeLoaded) begin
            sinceRefresh++;
            assert (spacingReported || sinceRefresh <= RefreshLimit) else begin
                $display("model: no refresh within %0d cycles", RefreshLimit);
                ErrorCount++;
                spacingReported = 1'b1;
            end
        end
        if (!keyDrawn && Cke && (cmd == CmdRead || cmd == CmdWrite)) begin
            fillKey  = $urandom;
            keyDrawn = 1'b1;
        end
        if (Cke) begin
            case (cmd)
                CmdPrecharge: begin
                    for (int b = 0; b < 4; b++) begin
                        if (Addr[PrechargeAllBit] || bankT'(b) == Bank) begin
                            bankOpen[b] = 1'b0;
                        end
                    end
                end
                CmdActive: begin
                    assert (modeLoaded) else begin
                        $display("model: activate before the mode register load");
                        ErrorCount++;
                    end
                    assert (!bankOpen[Bank]) else begin
                        $display("model: activate on bank %0d without a precharge", Bank);
                        ErrorCount++;
                    end
                    bankOpen[Bank] = 1'b1;
                    openRow[Bank]  = Addr;
                end
                CmdRead: begin
                    assert (bankOpen[Bank]) else begin
                        $display("model: read on bank %0d with no open row", Bank);
                        ErrorCount++;
                    end
                    pipeValid[CasLatency - 1] = 1'b1;
                    pipeData[CasLatency - 1]  = storedWord(wordAddr);
                end
                CmdWrite: begin
                    assert (bankOpen[Bank]) else begin
                        $display("model: write on bank %0d with no open row", Bank);
                        ErrorCount++;
                    end
                    word = storedWord(wordAddr);
                    for (int i = 0; i < 4; i++) begin
                        if (!Dqm[i]) begin
                            word[8*i +: 8] = DqIn[8*i +: 8];   // mask bit 1 keeps the byte
                        end
                    end
                    mem[wordAddr] = word;
                end
                CmdRefresh: begin
                    assert (!(bankOpen[0] || bankOpen[1] || bankOpen[2] || bankOpen[3]))
                    else begin
                        $display("model: refresh with a bank still open");
                        ErrorCount++;
                    end
                    sinceRefresh    = 0;
                    spacingReported = 1'b0;
                end
                CmdLoadMode: begin
                    assert (Addr == ModeWord) else begin
                        $display("[ERROR] ChipAddr at mode load: got %h expected %h",
                                 Addr, ModeWord);
                        ErrorCount++;
                    end
                    modeLoaded   = 1'b1;
                    sinceRefresh = 0;
                end
                default: ;
            endcase
        end
    end

endmodule

// File: verif/sdramCoreTb.sv
// Testbench for the SDRAM controller
// clock and reset, stimulus table applied in a loop
// init and handshake monitors, read data checks, cycle timeout
module sdramCoreTb
    import sdramPkg::*;
();

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 5;
    localparam int DriveDelay  = 1;
    localparam int NumSteps    = 15;
    localparam int unsigned RandSeed = 32'h23b5792a;

    typedef struct packed {
        logic     write;
        hostAddrT addr;
        dataT     data;
        maskT     mask;
        dataT     expected;                         // read steps only
        int       gap;                              // idle cycles after the step
    } stepT;

    logic     Clk;
    logic     reset;
    logic     Req;
    logic     Write;
    hostAddrT Addr;
    dataT     WrData;
    maskT     WrMask;
    logic     Ack;
    dataT     RdData;
    logic     InitDone;
    dataT     ChipDin;
    dataT     ChipDout;
    chipAddrT ChipAddr;
    bankT     ChipBank;
    logic     ChipClk;
    logic     ChipCke;
    logic     ChipCsN;
    logic     ChipRasN;
    logic     ChipCasN;
    logic     ChipWeN;
    maskT     ChipDqm;

    stepT steps [NumSteps];
    int   stepCount;
    int   cycleCount;
    int   cycleLimit;
    int   errorCount;
    int   modelErrors;
    int   passCount;
    int   failCount;
    bit   monitorOn;
    bit   ackLast;

    sdramCore sdramCore_i (.*);

    sdramModel sdramModel_i (
        .Clk        (ChipClk),
        .Cke        (ChipCke),
        .CsN        (ChipCsN),
        .RasN       (ChipRasN),
        .CasN       (ChipCasN),
        .WeN        (ChipWeN),
        .Addr       (ChipAddr),
        .Bank       (ChipBank),
        .Dqm        (ChipDqm),
        .DqIn       (ChipDout),
        .DqOut      (ChipDin),
        .ErrorCount (modelErrors)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run stopped after %0d cycles", cycleCount);
            $display("Test FAILED");
            $finish;
        end
    end

    // Ack must stay low through init and may only rise while Req is high
    always @(negedge Clk) begin
        if (monitorOn) begin
            assert (InitDone || !Ack) else begin
                $display("Ack went high before init finished");
                errorCount++;
            end
            assert (!Ack || ackLast || Req) else begin
                $display("Ack rose while Req was low");
                errorCount++;
            end
            ackLast <= Ack;
        end
    end

    function automatic hostAddrT makeAddr(bankT bank, rowT row, colT col);
        return {bank, row, col};
    endfunction

    task automatic addStep(input logic wr, input hostAddrT addr, input dataT data,
                           input maskT mask, input dataT expected, input int gap);
        steps[stepCount] = '{wr, addr, data, mask, expected, gap};
        stepCount++;
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount + modelErrors == errorsBefore) begin
            passCount++;
            $display("%s: ok", name);
        end else begin
            failCount++;
            $display("%s: failed", name);
        end
    endtask

    task automatic runStep(input int idx);
        stepT s;
        int   errorsBefore;
        int   holdCycles;
        dataT heldData;
        s            = steps[idx];
        errorsBefore = errorCount + modelErrors;
        holdCycles   = 1 + ($urandom % 3);      // extra cycles with Req high after Ack
        @(negedge Clk);
        assert (!Ack) else begin
            $display("step %0d: Ack still high before the next Req", idx);
            errorCount++;
        end
        @(posedge Clk);
        #DriveDelay;
        Req    = 1'b1;
        Write  = s.write;
        Addr   = s.addr;
        WrData = s.data;
        WrMask = s.mask;
        do begin
            @(negedge Clk);
        end while (!Ack);
        heldData = RdData;
        if (!s.write) begin
            assert (RdData == s.expected) else begin
                $display("[ERROR] step %0d RdData: got %h expected %h",
                         idx, RdData, s.expected);
                errorCount++;
            end
        end
        repeat (holdCycles) begin
            @(negedge Clk);
            assert (Ack) else begin
                $display("step %0d: Ack dropped while Req was high", idx);
                errorCount++;
            end
            assert (RdData == heldData) else begin
                $display("[ERROR] step %0d RdData during hold: got %h expected %h",
                         idx, RdData, heldData);
                errorCount++;
            end
        end
        @(posedge Clk);
        #DriveDelay;
        Req = 1'b0;
        do begin
            @(negedge Clk);
        end while (Ack);
        repeat (s.gap) @(posedge Clk);
        reportTest($sformatf("step %0d %s addr %h", idx, s.write ? "write" : "read", s.addr),
                   errorsBefore);
    endtask

    task automatic buildSteps();
        hostAddrT a0;
        hostAddrT a1;
        hostAddrT a2;
        hostAddrT a3;
        a0 = makeAddr(2'd0, 11'd5, 8'h10);
        a1 = makeAddr(2'd0, 11'd6, 8'h10);              // same bank, other row
        a2 = makeAddr(2'd1, 11'd5, 8'h10);              // same row, other bank
        a3 = makeAddr(2'd3, 11'h7ff, 8'h10);
        addStep(1'b1, a0, 32'h1234_5678, 4'b0000, '0, 2);
        addStep(1'b0, a0, '0, 4'b0000, 32'h1234_5678, 1);
        addStep(1'b1, a0, 32'haabb_ccdd, 4'b0101, '0, 0);
        addStep(1'b0, a0, '0, 4'b0000, 32'haa34_cc78, 1);
        addStep(1'b1, a1, 32'h1111_1111, 4'b0000, '0, 0);
        addStep(1'b1, a2, 32'h2222_2222, 4'b0000, '0, 0);
        addStep(1'b1, a3, 32'h3333_3333, 4'b0000, '0, 3);
        addStep(1'b0, a0, '0, 4'b0000, 32'haa34_cc78, 0);
        addStep(1'b0, a1, '0, 4'b0000, 32'h1111_1111, 0);
        addStep(1'b0, a2, '0, 4'b0000, 32'h2222_2222, 0);
        addStep(1'b0, a3, '0, 4'b0000, 32'h3333_3333, 3 * RefreshInterval + 30);
        addStep(1'b0, a0, '0, 4'b0000, 32'haa34_cc78, 0);
        addStep(1'b0, a3, '0, 4'b0000, 32'h3333_3333, 2);
        addStep(1'b1, a2, 32'hdead_beef, 4'b1110, '0, 0);
        addStep(1'b0, a2, '0, 4'b0000, 32'h2222_22ef, 1);
    endtask

    initial begin
        int errorsBefore;
        void'($urandom(RandSeed));
        reset     = 1'b1;
        Req       = 1'b0;
        Write     = 1'b0;
        Addr      = '0;
        WrData    = '0;
        WrMask    = '0;
        buildSteps();
        cycleLimit = InitWaitCycles + 200 + 60 * NumSteps;
        for (int i = 0; i < NumSteps; i++) begin
            cycleLimit += steps[i].gap;
        end
        repeat (ResetCycles) @(posedge Clk);
        #DriveDelay;
        reset     = 1'b0;
        monitorOn = 1'b1;
        errorsBefore = errorCount + modelErrors;
        // first request waits while init runs
        Req    = 1'b1;
        Write  = steps[0].write;
        Addr   = steps[0].addr;
        WrData = steps[0].data;
        WrMask = steps[0].mask;
        while (!InitDone) @(negedge Clk);
        reportTest("init", errorsBefore);
        for (int i = 0; i < NumSteps; i++) begin
            runStep(i);
        end
        $display("tests %0d, passed %0d, failed %0d, check errors %0d, model errors %0d",
                 passCount + failCount, passCount, failCount, errorCount, modelErrors);
        if (failCount == 0 && errorCount == 0 && modelErrors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
design/sdramPkg.sv
design/sdramInit.sv
design/refreshEngine.sv
design/accessSequencer.sv
design/sdramCore.sv
verif/sdramModel.sv
verif/sdramCoreTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = sdramCoreTb
FILELIST = sources.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSMSG  = Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASSMSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)
